// ==== Makefile ====
# Verilator build and run of the SoC interconnect testbench
SIM := obj_dir/Vtb_soc_interconnect

.PHONY: run clean

run: $(SIM)
	./$(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): sources.f $(wildcard source/*.sv) sim/tb_soc_interconnect.sv
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_soc_interconnect -f sources.f

clean:
	rm -rf obj_dir

// ==== sim/tb_soc_interconnect.sv ====
// SoC interconnect testbench
// Drives the three TCDM masters from a stimulus table, models the four
// banks and the contiguous memory, and checks routing, read data, error
// answers and round-robin service under bank contention
`timescale 1ns/1ps
`default_nettype none

module tb_soc_interconnect import soc_ic_pkg::*; ();

    // Number of stimulus table rows as counted in build_table
    localparam int NR_ROWS        = 43;
    localparam int TIMEOUT_CYCLES = 20 * NR_ROWS + 200;
    localparam int MEM_WORDS      = 1 << BANK_OFFSET_WIDTH;

    typedef struct packed {
        logic [1:0] mst;
        addr_t      addr;
        logic       wen;
        data_t      wdata;
        data_t      exp_rdata;
        logic       exp_opc;
        target_e    route;
    } row_t;

    logic        clk = 1'b0;
    logic        arst_n;
    tcdm_req_t   master_req [NR_MASTERS];
    tcdm_rsp_t   master_rsp [NR_MASTERS];
    tcdm_req_t   bank_req   [NR_BANKS];
    tcdm_rsp_t   bank_rsp   [NR_BANKS];
    tcdm_req_t   contig_req;
    tcdm_rsp_t   contig_rsp;

    row_t        table_q [NR_ROWS];
    int          nr_rows = 0;
    int          seed = 32'h7e33_953d;
    int unsigned cycle_cnt = 0;
    addr_t       hot_addr [NR_MASTERS];
    data_t       hot_data [NR_MASTERS];

    // Behavioural memories behind the bank and contiguous ports
    data_t       bank_mem [NR_BANKS][MEM_WORDS];
    data_t       bank_rdata_q [NR_BANKS];
    logic        bank_valid_q [NR_BANKS];
    data_t       contig_mem [MEM_WORDS];
    data_t       contig_rdata_q;
    logic        contig_valid_q;

    always #4 clk = ~clk;

    soc_interconnect i_soc_interconnect (
        .clk_i        (clk),
        .arst_n_i     (arst_n),
        .master_req_i (master_req),
        .master_rsp_o (master_rsp),
        .bank_req_o   (bank_req),
        .bank_rsp_i   (bank_rsp),
        .contig_req_o (contig_req),
        .contig_rsp_i (contig_rsp)
    );

    ////////////////////////////////////////
    // Memory models
    ////////////////////////////////////////
    function automatic data_t merge_bytes(input data_t old, input data_t wdata, input be_t be);
        data_t res;
        res = old;
        for (int i = 0; i < int'(BE_WIDTH); i++) begin
            if (be[i]) begin
                res[8*i +: 8] = wdata[8*i +: 8];
            end
        end
        return res;
    endfunction

    // Slaves grant in the request cycle and answer in the next one
    always_comb begin
        for (int b = 0; b < int'(NR_BANKS); b++) begin
            bank_rsp[b].gnt     = bank_req[b].req;
            bank_rsp[b].r_valid = bank_valid_q[b];
            bank_rsp[b].r_rdata = bank_rdata_q[b];
            bank_rsp[b].r_opc   = 1'b0;
        end
        contig_rsp.gnt     = contig_req.req;
        contig_rsp.r_valid = contig_valid_q;
        contig_rsp.r_rdata = contig_rdata_q;
        contig_rsp.r_opc   = 1'b0;
    end

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int b = 0; b < int'(NR_BANKS); b++) begin
                bank_valid_q[b] <= 1'b0;
            end
            contig_valid_q <= 1'b0;
        end else begin
            for (int b = 0; b < int'(NR_BANKS); b++) begin
                bank_valid_q[b] <= bank_req[b].req;
            end
            contig_valid_q <= contig_req.req;
        end
    end

    always @(posedge clk) begin
        for (int b = 0; b < int'(NR_BANKS); b++) begin
            if (bank_req[b].req && bank_req[b].wen) begin
                bank_rdata_q[b] <= bank_mem[b][bank_req[b].add[BANK_OFFSET_WIDTH-1:0]];
            end else if (bank_req[b].req) begin
                bank_mem[b][bank_req[b].add[BANK_OFFSET_WIDTH-1:0]] <= merge_bytes(
                    bank_mem[b][bank_req[b].add[BANK_OFFSET_WIDTH-1:0]],
                    bank_req[b].wdata, bank_req[b].be);
            end
        end
        if (contig_req.req && contig_req.wen) begin
            contig_rdata_q <= contig_mem[contig_req.add[CONTIG_OFFSET_WIDTH-1:0]];
        end else if (contig_req.req) begin
            contig_mem[contig_req.add[CONTIG_OFFSET_WIDTH-1:0]] <= merge_bytes(
                contig_mem[contig_req.add[CONTIG_OFFSET_WIDTH-1:0]],
                contig_req.wdata, contig_req.be);
        end
    end

    ////////////////////////////////////////
    // Checking and run limit
    ////////////////////////////////////////
    task automatic report_failure(input string reason);
        $display("%s", reason);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
            report_failure("a DUT output did not match its expected value");
        end
    endtask

    // Ends a run that stalls waiting on a grant
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            report_failure("run did not finish within the cycle limit");
        end
    end

    ////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////
    task automatic add_row(input int m, input addr_t addr, input logic wen, input data_t wdata,
                           input data_t exp_rdata, input logic exp_opc, input target_e route);
        row_t row;
        row.mst       = 2'(m);
        row.addr      = addr;
        row.wen       = wen;
        row.wdata     = wdata;
        row.exp_rdata = exp_rdata;
        row.exp_opc   = exp_opc;
        row.route     = route;
        if (nr_rows < NR_ROWS) begin
            table_q[nr_rows] = row;
        end
        nr_rows++;
    endtask

    // A write followed by a read of the same word
    task automatic add_pair(input int m, input addr_t addr, input target_e route);
        data_t data;
        data = $random(seed);
        if (route == TGT_ERROR) begin
            // Decode errors answer writes with zero and reads with the error word
            add_row(m, addr, 1'b0, data, '0, 1'b1, route);
            add_row(m, addr, 1'b1, '0, ERROR_WORD, 1'b1, route);
        end else begin
            add_row(m, addr, 1'b0, data, '0, 1'b0, route);
            add_row(m, addr, 1'b1, '0, data, 1'b0, route);
        end
    endtask

    task automatic build_table();
        addr_t addr;
        // Every master touches every bank once at a random word
        for (int m = 0; m < int'(NR_MASTERS); m++) begin
            for (int b = 0; b < int'(NR_BANKS); b++) begin
                addr = INTLVD_BASE | (addr_t'($random(seed)) & 32'h0000_FFF0) | (addr_t'(b) << 2);
                add_pair(m, addr, TGT_INTLVD);
            end
        end
        // Full masters use the contiguous memory
        for (int m = 0; m < int'(NR_FULL_MASTERS); m++) begin
            for (int k = 0; k < 2; k++) begin
                addr = CONTIG_BASE | (addr_t'($random(seed)) & 32'h0000_3FFC);
                add_pair(m, addr, TGT_CONTIG);
            end
        end
        // The interleaved-only master is refused the contiguous memory
        add_pair(2, CONTIG_BASE + 32'h0000_0010, TGT_ERROR);
        // Addresses outside both regions, including just past each end
        add_pair(0, 32'h2000_0000, TGT_ERROR);
        add_pair(1, INTLVD_BASE + INTLVD_SIZE, TGT_ERROR);
        add_pair(2, CONTIG_BASE + CONTIG_SIZE, TGT_ERROR);
        // Three words in bank 1 for the contention test
        for (int m = 0; m < int'(NR_MASTERS); m++) begin
            hot_addr[m] = INTLVD_BASE + 32'h0000_0104 + (addr_t'(m) << 8);
            hot_data[m] = $random(seed);
            add_row(0, hot_addr[m], 1'b0, hot_data[m], '0, 1'b0, TGT_INTLVD);
        end
    endtask

    ////////////////////////////////////////
    // Test sequences
    ////////////////////////////////////////
    task automatic check_reset_state();
        @(negedge clk);
        for (int m = 0; m < int'(NR_MASTERS); m++) begin
            check_value($sformatf("master_rsp_o[%0d].gnt", m), data_t'(master_rsp[m].gnt), '0);
            check_value($sformatf("master_rsp_o[%0d].r_valid", m),
                        data_t'(master_rsp[m].r_valid), '0);
        end
        for (int b = 0; b < int'(NR_BANKS); b++) begin
            check_value($sformatf("bank_req_o[%0d].req", b), data_t'(bank_req[b].req), '0);
        end
        check_value("contig_req_o.req", data_t'(contig_req.req), '0);
    endtask

    // In the grant cycle only the expected slave port carries the request
    task automatic check_route(input row_t row);
        bank_sel_t sel;
        logic      exp_req;
        sel = row.addr[3:2];
        for (int b = 0; b < int'(NR_BANKS); b++) begin
            exp_req = (row.route == TGT_INTLVD) && (sel == bank_sel_t'(b));
            check_value($sformatf("bank_req_o[%0d].req", b), data_t'(bank_req[b].req),
                        data_t'(exp_req));
        end
        if (row.route == TGT_INTLVD) begin
            check_value($sformatf("bank_req_o[%0d].add", sel), bank_req[sel].add,
                        data_t'(row.addr[15:4]));
        end
        check_value("contig_req_o.req", data_t'(contig_req.req),
                    data_t'(row.route == TGT_CONTIG));
        if (row.route == TGT_CONTIG) begin
            check_value("contig_req_o.add", contig_req.add, data_t'(row.addr[13:2]));
        end
    endtask

    task automatic apply_row(input row_t row);
        int        m;
        tcdm_req_t req;
        m         = int'(row.mst);
        req.req   = 1'b1;
        req.add   = row.addr;
        req.wen   = row.wen;
        req.wdata = row.wdata;
        req.be    = '1;
        @(posedge clk);
        master_req[m] <= req;
        @(negedge clk);
        while (!master_rsp[m].gnt) begin
            @(negedge clk);
        end
        check_route(row);
        @(posedge clk);
        master_req[m].req <= 1'b0;
        // The response follows the grant by exactly one cycle
        @(negedge clk);
        check_value($sformatf("master_rsp_o[%0d].r_valid", m),
                    data_t'(master_rsp[m].r_valid), 32'd1);
        check_value($sformatf("master_rsp_o[%0d].r_opc", m),
                    data_t'(master_rsp[m].r_opc), data_t'(row.exp_opc));
        if (row.wen || row.exp_opc) begin
            check_value($sformatf("master_rsp_o[%0d].r_rdata", m),
                        master_rsp[m].r_rdata, row.exp_rdata);
        end
    endtask

    // All masters read bank 1 at once and get one grant per cycle for three cycles
    task automatic run_contention();
        tcdm_req_t             req;
        int                    won;
        int                    prev;
        int                    nr_gnt;
        logic [NR_MASTERS-1:0] done;
        prev = -1;
        done = '0;
        @(posedge clk);
        for (int m = 0; m < int'(NR_MASTERS); m++) begin
            req.req   = 1'b1;
            req.add   = hot_addr[m];
            req.wen   = 1'b1;
            req.wdata = '0;
            req.be    = '1;
            master_req[m] <= req;
        end
        for (int cyc = 1; cyc <= int'(NR_MASTERS) + 1; cyc++) begin
            @(negedge clk);
            if (prev >= 0) begin
                check_value($sformatf("master_rsp_o[%0d].r_valid", prev),
                            data_t'(master_rsp[prev].r_valid), 32'd1);
                check_value($sformatf("master_rsp_o[%0d].r_rdata", prev),
                            master_rsp[prev].r_rdata, hot_data[prev]);
            end
            nr_gnt = 0;
            won    = -1;
            for (int m = 0; m < int'(NR_MASTERS); m++) begin
                if (master_rsp[m].gnt) begin
                    nr_gnt++;
                    won     = m;
                    done[m] = 1'b1;
                end
            end
            check_value("grants on bank 1", data_t'(nr_gnt),
                        data_t'((cyc <= int'(NR_MASTERS)) ? 1 : 0));
            prev = won;
            if (won >= 0) begin
                @(posedge clk);
                master_req[won].req <= 1'b0;
            end
        end
        check_value("masters served", data_t'(done), data_t'({NR_MASTERS{1'b1}}));
    endtask

    initial begin
        for (int m = 0; m < int'(NR_MASTERS); m++) begin
            master_req[m] = '0;
        end
        arst_n = 1'b0;
        build_table();
        if (nr_rows != NR_ROWS) begin
            report_failure("stimulus table size differs from NR_ROWS");
        end
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
        check_reset_state();
        for (int r = 0; r < NR_ROWS; r++) begin
            apply_row(table_q[r]);
        end
        run_contention();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule : tb_soc_interconnect

`default_nettype wire

// ==== source/interleaved_xbar.sv ====
// Interleaved TCDM crossbar
// Picks the bank from word address bits 3:2, rewrites the address to
// the bank-local word index and arbitrates each bank round-robin
`timescale 1ns/1ps
`default_nettype none

module interleaved_xbar import soc_ic_pkg::*; (
    input  wire logic      clk_i,
    input  wire logic      arst_n_i,
    input  wire tcdm_req_t mst_req_i [NR_MASTERS],
    output tcdm_rsp_t      mst_rsp_o [NR_MASTERS],
    output tcdm_req_t      bank_req_o [NR_BANKS],
    input  wire tcdm_rsp_t bank_rsp_i [NR_BANKS]
);

    bank_sel_t    bank_sel   [NR_MASTERS];
    bank_sel_t    bank_sel_q [NR_MASTERS];
    bank_offset_t bank_off   [NR_MASTERS];
    tcdm_req_t    arb_req    [NR_BANKS][NR_MASTERS];
    tcdm_rsp_t    arb_rsp    [NR_BANKS][NR_MASTERS];

    ////////////////////////////////////////
    // Bank select and address rewrite
    ////////////////////////////////////////
    always_comb begin
        for (int unsigned m = 0; m < NR_MASTERS; m++) begin
            bank_sel[m] = mst_req_i[m].add[BANK_SEL_WIDTH+1:2];
            bank_off[m] = mst_req_i[m].add[BANK_OFFSET_WIDTH+BANK_SEL_WIDTH+1:BANK_SEL_WIDTH+2];
        end
        for (int unsigned b = 0; b < NR_BANKS; b++) begin
            for (int unsigned m = 0; m < NR_MASTERS; m++) begin
                arb_req[b][m]     = mst_req_i[m];
                arb_req[b][m].req = mst_req_i[m].req && (bank_sel[m] == bank_sel_t'(b));
                arb_req[b][m].add = addr_t'(bank_off[m]);
            end
        end
    end

    // One arbiter per bank keeps that bank's winner for the response
    for (genvar b = 0; b < NR_BANKS; b++) begin : gen_bank_arb
        tcdm_rr_arbiter #(
            .NR_INPUTS (NR_MASTERS)
        ) i_bank_arb (
            .clk_i,
            .arst_n_i,
            .req_i     (arb_req[b]),
            .rsp_o     (arb_rsp[b]),
            .slv_req_o (bank_req_o[b]),
            .slv_rsp_i (bank_rsp_i[b])
        );
    end

    // Bank each master was granted by, used to merge the next response
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int unsigned m = 0; m < NR_MASTERS; m++) begin
                bank_sel_q[m] <= '0;
            end
        end else begin
            for (int unsigned m = 0; m < NR_MASTERS; m++) begin
                if (mst_rsp_o[m].gnt) begin
                    bank_sel_q[m] <= bank_sel[m];
                end
            end
        end
    end

    always_comb begin
        for (int unsigned m = 0; m < NR_MASTERS; m++) begin
            mst_rsp_o[m]     = arb_rsp[bank_sel_q[m]][m];
            mst_rsp_o[m].gnt = arb_rsp[bank_sel[m]][m].gnt;
        end
    end

endmodule : interleaved_xbar

`default_nettype wire

// ==== source/soc_ic_pkg.sv ====
// SoC interconnect package
// Holds the bus widths, the fixed address map, the decode error word
// and the TCDM request and response structs shared by every block
`default_nettype none

package soc_ic_pkg;

    ////////////////////////////////////////
    // Bus widths
    ////////////////////////////////////////
    localparam int unsigned ADDR_WIDTH = 32;
    localparam int unsigned DATA_WIDTH = 32;
    localparam int unsigned BE_WIDTH   = 4;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [BE_WIDTH-1:0]   be_t;

    // Two masters see the whole map, one only the interleaved region
    localparam int unsigned NR_FULL_MASTERS        = 2;
    localparam int unsigned NR_INTLVD_ONLY_MASTERS = 1;
    localparam int unsigned NR_MASTERS = NR_FULL_MASTERS + NR_INTLVD_ONLY_MASTERS;

    ////////////////////////////////////////
    // Address map
    ////////////////////////////////////////
    // Banks are selected by word address bits 3:2
    localparam int unsigned NR_BANKS          = 4;
    localparam int unsigned BANK_SEL_WIDTH    = 2;
    // Word index inside one bank comes from address bits 15:4
    localparam int unsigned BANK_OFFSET_WIDTH = 12;

    typedef logic [BANK_SEL_WIDTH-1:0]    bank_sel_t;
    typedef logic [BANK_OFFSET_WIDTH-1:0] bank_offset_t;

    localparam addr_t INTLVD_BASE = 32'h1C00_0000;
    localparam addr_t INTLVD_SIZE = 32'h0001_0000;
    localparam addr_t CONTIG_BASE = 32'h1A00_0000;
    localparam addr_t CONTIG_SIZE = 32'h0000_4000;

    // 16 KiB of words, so the index is address bits 13:2
    localparam int unsigned CONTIG_OFFSET_WIDTH = 12;
    typedef logic [CONTIG_OFFSET_WIDTH-1:0] contig_offset_t;

    // Read data returned on a decode error
    localparam data_t ERROR_WORD = 32'hBADA_CCE5;

    ////////////////////////////////////////
    // TCDM bus structs
    ////////////////////////////////////////
    typedef struct packed {
        logic  req;
        addr_t add;
        logic  wen;   // 1 means read
        data_t wdata;
        be_t   be;
    } tcdm_req_t;

    typedef struct packed {
        logic  gnt;
        logic  r_valid;
        data_t r_rdata;
        logic  r_opc;
    } tcdm_rsp_t;

    // Route chosen by the per-master decoder
    typedef enum logic [1:0] {
        TGT_INTLVD,
        TGT_CONTIG,
        TGT_ERROR
    } target_e;

endpackage : soc_ic_pkg

`default_nettype wire

// ==== source/soc_interconnect.sv ====
// SoC memory interconnect top level
// Decodes every master's TCDM requests onto four interleaved banks,
// one contiguous memory or a local error responder
`timescale 1ns/1ps
`default_nettype none

module soc_interconnect import soc_ic_pkg::*; (
    input  wire logic      clk_i,
    input  wire logic      arst_n_i,
    input  wire tcdm_req_t master_req_i [NR_MASTERS],
    output tcdm_rsp_t      master_rsp_o [NR_MASTERS],
    output tcdm_req_t      bank_req_o [NR_BANKS],
    input  wire tcdm_rsp_t bank_rsp_i [NR_BANKS],
    output tcdm_req_t      contig_req_o,
    input  wire tcdm_rsp_t contig_rsp_i
);

    tcdm_req_t intlvd_req [NR_MASTERS];
    tcdm_rsp_t intlvd_rsp [NR_MASTERS];
    tcdm_req_t contig_req [NR_FULL_MASTERS];
    tcdm_rsp_t contig_rsp [NR_FULL_MASTERS];

    ////////////////////////////////////////
    // Address decoders
    ////////////////////////////////////////
    for (genvar i = 0; i < NR_MASTERS; i++) begin : gen_decoder
        if (i < NR_FULL_MASTERS) begin : gen_full
            tcdm_addr_decoder #(
                .ALLOW_CONTIG (1'b1)
            ) i_decoder (
                .clk_i,
                .arst_n_i,
                .req_i        (master_req_i[i]),
                .rsp_o        (master_rsp_o[i]),
                .intlvd_req_o (intlvd_req[i]),
                .intlvd_rsp_i (intlvd_rsp[i]),
                .contig_req_o (contig_req[i]),
                .contig_rsp_i (contig_rsp[i])
            );
        end else begin : gen_intlvd_only
            // Restricted masters have no contiguous path at all
            tcdm_addr_decoder #(
                .ALLOW_CONTIG (1'b0)
            ) i_decoder (
                .clk_i,
                .arst_n_i,
                .req_i        (master_req_i[i]),
                .rsp_o        (master_rsp_o[i]),
                .intlvd_req_o (intlvd_req[i]),
                .intlvd_rsp_i (intlvd_rsp[i]),
                .contig_req_o (),
                .contig_rsp_i ('0)
            );
        end
    end

    ////////////////////////////////////////
    // Targets
    ////////////////////////////////////////
    interleaved_xbar i_interleaved_xbar (
        .clk_i,
        .arst_n_i,
        .mst_req_i  (intlvd_req),
        .mst_rsp_o  (intlvd_rsp),
        .bank_req_o (bank_req_o),
        .bank_rsp_i (bank_rsp_i)
    );

    // Only the full masters compete for the contiguous port
    tcdm_rr_arbiter #(
        .NR_INPUTS (NR_FULL_MASTERS)
    ) i_contig_arb (
        .clk_i,
        .arst_n_i,
        .req_i     (contig_req),
        .rsp_o     (contig_rsp),
        .slv_req_o (contig_req_o),
        .slv_rsp_i (contig_rsp_i)
    );

endmodule : soc_interconnect

`default_nettype wire

// ==== source/tcdm_addr_decoder.sv ====
// Per-master TCDM address decoder
// Sends each request to the interleaved, contiguous or error target
// and steers the response of the granted target back one cycle later
`timescale 1ns/1ps
`default_nettype none

module tcdm_addr_decoder import soc_ic_pkg::*; #(
    parameter bit ALLOW_CONTIG = 1'b1
) (
    input  wire logic      clk_i,
    input  wire logic      arst_n_i,
    input  wire tcdm_req_t req_i,
    output tcdm_rsp_t      rsp_o,
    output tcdm_req_t      intlvd_req_o,
    input  wire tcdm_rsp_t intlvd_rsp_i,
    output tcdm_req_t      contig_req_o,
    input  wire tcdm_rsp_t contig_rsp_i
);

    target_e        tgt_d;
    target_e        tgt_q;
    contig_offset_t contig_off;
    tcdm_req_t      err_req;
    tcdm_rsp_t      err_rsp;

    ////////////////////////////////////////
    // Address classification
    ////////////////////////////////////////
    always_comb begin
        tgt_d = TGT_ERROR;
        if (req_i.add >= INTLVD_BASE && req_i.add < INTLVD_BASE + INTLVD_SIZE) begin
            tgt_d = TGT_INTLVD;
        end else if (req_i.add >= CONTIG_BASE && req_i.add < CONTIG_BASE + CONTIG_SIZE) begin
            // Restricted masters hitting contiguous memory end up at the error slave
            tgt_d = ALLOW_CONTIG ? TGT_CONTIG : TGT_ERROR;
        end
    end

    // Word index inside the contiguous memory
    assign contig_off = req_i.add[CONTIG_OFFSET_WIDTH+1:2];

    // Only the selected target sees req, everything else is a copy
    always_comb begin
        intlvd_req_o     = req_i;
        intlvd_req_o.req = req_i.req && (tgt_d == TGT_INTLVD);

        contig_req_o     = req_i;
        contig_req_o.add = addr_t'(contig_off);
        contig_req_o.req = req_i.req && (tgt_d == TGT_CONTIG);

        err_req          = req_i;
        err_req.req      = req_i.req && (tgt_d == TGT_ERROR);
    end

    tcdm_error_slave i_error_slave (
        .clk_i,
        .arst_n_i,
        .req_i (err_req),
        .rsp_o (err_rsp)
    );

    ////////////////////////////////////////
    // Response steering
    ////////////////////////////////////////
    // Remember which target granted so the next cycle's response is taken from it
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            tgt_q <= TGT_ERROR;
        end else if (rsp_o.gnt) begin
            tgt_q <= tgt_d;
        end
    end

    always_comb begin
        rsp_o = err_rsp;
        // Grant comes from the target addressed in this cycle
        unique case (tgt_d)
            TGT_INTLVD: rsp_o.gnt = intlvd_rsp_i.gnt;
            TGT_CONTIG: rsp_o.gnt = contig_rsp_i.gnt;
            default:    rsp_o.gnt = err_rsp.gnt;
        endcase
        // Read channel comes from the target granted last cycle
        unique case (tgt_q)
            TGT_INTLVD: begin
                rsp_o.r_valid = intlvd_rsp_i.r_valid;
                rsp_o.r_rdata = intlvd_rsp_i.r_rdata;
                rsp_o.r_opc   = intlvd_rsp_i.r_opc;
            end
            TGT_CONTIG: begin
                rsp_o.r_valid = contig_rsp_i.r_valid;
                rsp_o.r_rdata = contig_rsp_i.r_rdata;
                rsp_o.r_opc   = contig_rsp_i.r_opc;
            end
            default: begin
                rsp_o.r_valid = err_rsp.r_valid;
                rsp_o.r_rdata = err_rsp.r_rdata;
                rsp_o.r_opc   = err_rsp.r_opc;
            end
        endcase
    end

    // Every response seen by the master belongs to a grant one cycle earlier
    a_rvalid_after_gnt : assert property (@(posedge clk_i) disable iff (!arst_n_i)
        rsp_o.r_valid |-> $past(rsp_o.gnt));

endmodule : tcdm_addr_decoder

`default_nettype wire

// ==== source/tcdm_error_slave.sv ====
// TCDM error responder
// Grants at once and answers in the next cycle with the opc flag set,
// returning the error word for reads and zero for writes
`timescale 1ns/1ps
`default_nettype none

module tcdm_error_slave import soc_ic_pkg::*; (
    input  wire logic      clk_i,
    input  wire logic      arst_n_i,
    input  wire tcdm_req_t req_i,
    output tcdm_rsp_t      rsp_o
);

    logic  valid_q;
    data_t rdata_q;

    // Response flag follows every accepted request by one cycle
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= req_i.req;
        end
    end

    // Reads see the error word, writes see zero
    always_ff @(posedge clk_i) begin
        rdata_q <= req_i.wen ? ERROR_WORD : '0;
    end

    always_comb begin
        rsp_o.gnt     = req_i.req;
        rsp_o.r_valid = valid_q;
        rsp_o.r_rdata = rdata_q;
        // The opc line marks every answer from here as a bus error
        rsp_o.r_opc   = valid_q;
    end

endmodule : tcdm_error_slave

`default_nettype wire

// ==== source/tcdm_rr_arbiter.sv ====
// Round-robin TCDM arbiter for one slave port
// Grants one master per cycle, starting after the last winner, and
// routes the slave's read data back to that winner one cycle later
`timescale 1ns/1ps
`default_nettype none

module tcdm_rr_arbiter import soc_ic_pkg::*; #(
    parameter int unsigned NR_INPUTS = 3
) (
    input  wire logic      clk_i,
    input  wire logic      arst_n_i,
    input  wire tcdm_req_t req_i [NR_INPUTS],
    output tcdm_rsp_t      rsp_o [NR_INPUTS],
    output tcdm_req_t      slv_req_o,
    input  wire tcdm_rsp_t slv_rsp_i
);

    localparam int unsigned IDX_WIDTH = (NR_INPUTS > 1) ? $clog2(NR_INPUTS) : 1;

    logic [IDX_WIDTH-1:0] rr_q;
    logic [IDX_WIDTH-1:0] win_idx;
    logic [IDX_WIDTH-1:0] win_q;
    logic                 any_req;
    logic                 granted;
    logic                 valid_q;
    logic [NR_INPUTS-1:0] req_vec;

    ////////////////////////////////////////
    // Winner selection
    ////////////////////////////////////////
    // Scan from the farthest input back to the nearest one after the
    // pointer, so the nearest requester is the one left in win_idx
    always_comb begin
        int unsigned idx;
        win_idx = rr_q;
        any_req = 1'b0;
        for (int unsigned off = NR_INPUTS; off >= 1; off--) begin
            idx = (int'(rr_q) + off) % NR_INPUTS;
            if (req_i[idx].req) begin
                win_idx = IDX_WIDTH'(idx);
                any_req = 1'b1;
            end
        end
    end

    // A transfer happens only when the slave accepts as well
    assign granted = any_req && slv_rsp_i.gnt;

    always_comb begin
        slv_req_o     = req_i[win_idx];
        slv_req_o.req = any_req;
    end

    ////////////////////////////////////////
    // Pointer and return path
    ////////////////////////////////////////
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rr_q    <= '0;
            win_q   <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= granted;
            if (granted) begin
                // Last winner moves to the back of the queue
                rr_q  <= win_idx;
                win_q <= win_idx;
            end
        end
    end

    // Slave r_valid is implied by the grant, so the registered grant is used
    always_comb begin
        for (int unsigned i = 0; i < NR_INPUTS; i++) begin
            req_vec[i]       = req_i[i].req;
            rsp_o[i].gnt     = granted && (win_idx == IDX_WIDTH'(i));
            rsp_o[i].r_valid = valid_q && (win_q == IDX_WIDTH'(i));
            rsp_o[i].r_rdata = rsp_o[i].r_valid ? slv_rsp_i.r_rdata : '0;
            rsp_o[i].r_opc   = rsp_o[i].r_valid && slv_rsp_i.r_opc;
        end
    end

    // The last winner is served again only when no other master is waiting
    a_rr_fair : assert property (@(posedge clk_i) disable iff (!arst_n_i)
        granted && $past(granted) && (win_idx == $past(win_idx)) |-> $onehot(req_vec));

endmodule : tcdm_rr_arbiter

`default_nettype wire

// ==== sources.f ====
source/soc_ic_pkg.sv
source/tcdm_error_slave.sv
source/tcdm_rr_arbiter.sv
source/tcdm_addr_decoder.sv
source/interleaved_xbar.sv
source/soc_interconnect.sv
sim/tb_soc_interconnect.sv
